//--- vlog.f
+incdir+include
src/fp_cop_pkg.sv
src/slot_ram.sv
src/mod_arith_unit.sv
src/slot_ram_arbiter.sv
src/axi_lite_bridge.sv
src/inst_sequencer.sv
src/fp_coprocessor_top.sv
testbench/fp_coprocessor_sva.sv
testbench/tb_fp_coprocessor.sv

//--- run.sh
#!/bin/sh
# Build and run the coprocessor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module tb_fp_coprocessor -o tb_sim

out=$(./obj_dir/tb_sim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Test passed"; then
  exit 0
else
  exit 1
fi

//--- testbench/tb_fp_coprocessor.sv
// Testbench for the prime-field coprocessor
// Loads programs over AXI4-Lite and checks slot results against field arithmetic
`timescale 1ns/1ps
`include "fp_cop_params.svh"

module tb_fp_coprocessor;

  // About 5 cycles per status poll over 4 programs plus margin
  localparam int MAX_POLLS      = 800;
  localparam int TIMEOUT_CYCLES = 20000;

  logic        i_clk;
  logic        i_rst;
  logic [31:0] i_awaddr;
  logic        i_awvalid;
  logic        o_awready;
  logic [31:0] i_wdata;
  logic        i_wvalid;
  logic        o_wready;
  logic        o_bvalid;
  logic        i_bready;
  logic [31:0] i_araddr;
  logic        i_arvalid;
  logic        o_arready;
  logic [31:0] o_rdata;
  logic        o_rvalid;
  logic        i_rready;

  integer seed = 32'h4493;
  int     errors = 0;
  int     checks = 0;
  int     test_count = 0;
  int     cycle_count = 0;

  fp_coprocessor_top fp_coprocessor_top_inst (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_awaddr  (i_awaddr),
    .i_awvalid (i_awvalid),
    .o_awready (o_awready),
    .i_wdata   (i_wdata),
    .i_wvalid  (i_wvalid),
    .o_wready  (o_wready),
    .o_bvalid  (o_bvalid),
    .i_bready  (i_bready),
    .i_araddr  (i_araddr),
    .i_arvalid (i_arvalid),
    .o_arready (o_arready),
    .o_rdata   (o_rdata),
    .o_rvalid  (o_rvalid),
    .i_rready  (i_rready)
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run went past %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  // Reference field arithmetic modulo the 16-bit prime
  function automatic logic [15:0] field_sum(input logic [15:0] x, input logic [15:0] y);
    return 16'((32'(x) + 32'(y)) % `FE_MODULUS);
  endfunction

  function automatic logic [15:0] wrapped_diff(input logic [15:0] x, input logic [15:0] y);
    if (x >= y) begin
      return x - y;
    end
    return 16'(32'(x) + `FE_MODULUS - 32'(y));
  endfunction

  function automatic logic [15:0] reduced_product(input logic [15:0] x, input logic [15:0] y);
    longint unsigned p;
    p = 64'(x) * 64'(y);
    return 16'(p % `FE_MODULUS);
  endfunction

  function automatic logic [15:0] rand_operand();
    return 16'($unsigned($random(seed)) % `FE_MODULUS);
  endfunction

  function automatic fp_cop_pkg::inst_t encode_inst(input fp_cop_pkg::opcode_t op,
                                                    input logic [7:0] a, input logic [7:0] b,
                                                    input logic [7:0] c);
    fp_cop_pkg::inst_t w;
    w.opcode = op;
    w.rsvd   = 4'd0;
    w.a      = a;
    w.b      = b;
    w.c      = c;
    return w;
  endfunction

  task automatic expect_equal(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("CHECK FAILED at %0d ns: %s read %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // Host side AXI4-Lite driven on the falling edge
  task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                           input int resp_delay = 0);
    @(negedge i_clk);
    i_awaddr  = addr;
    i_wdata   = data;
    i_awvalid = 1'b1;
    i_wvalid  = 1'b1;
    @(negedge i_clk);
    while (!o_awready) @(negedge i_clk);
    // W channel ready rises with AW ready
    expect_equal("wready with awready", 32'(o_wready), 32'd1);
    @(negedge i_clk);
    i_awvalid = 1'b0;
    i_wvalid  = 1'b0;
    while (!o_bvalid) @(negedge i_clk);
    repeat (resp_delay) @(negedge i_clk);
    i_bready = 1'b1;
    @(negedge i_clk);
    i_bready = 1'b0;
  endtask

  task automatic axi_read(input logic [31:0] addr, output logic [31:0] data,
                          input int resp_delay = 0);
    @(negedge i_clk);
    i_araddr  = addr;
    i_arvalid = 1'b1;
    @(negedge i_clk);
    while (!o_arready) @(negedge i_clk);
    @(negedge i_clk);
    i_arvalid = 1'b0;
    while (!o_rvalid) @(negedge i_clk);
    repeat (resp_delay) @(negedge i_clk);
    data     = o_rdata;
    i_rready = 1'b1;
    @(negedge i_clk);
    i_rready = 1'b0;
  endtask

  task automatic write_slot(input int idx, input logic [15:0] val, input int resp_delay = 0);
    axi_write(`SLOT_BASE + 4 * idx, 32'(val), resp_delay);
  endtask

  task automatic check_slot(input int idx, input logic [15:0] exp, input int resp_delay = 0);
    logic [31:0] got;
    axi_read(`SLOT_BASE + 4 * idx, got, resp_delay);
    expect_equal($sformatf("slot %0d", idx), got, 32'(exp));
  endtask

  task automatic write_inst(input int idx, input fp_cop_pkg::inst_t w);
    axi_write(`INST_BASE + 4 * idx, 32'(w));
  endtask

  task automatic wait_idle();
    logic [31:0] ctrl;
    int          polls;
    polls = 0;
    axi_read(`REG_CTRL, ctrl);
    while (ctrl[31] && polls < MAX_POLLS) begin
      polls++;
      axi_read(`REG_CTRL, ctrl);
    end
    assert (!ctrl[31]) else begin
      $display("Sequencer still busy after %0d status polls", polls);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    test_count++;
    $display("[%0d] %s finished, %0d errors so far", test_count, name, errors);
  endtask

  logic [15:0] x;
  logic [15:0] y;
  logic [15:0] v;
  logic [15:0] chain [8];
  logic [31:0] rd;

  initial begin
    i_rst     = 1'b1;
    i_awaddr  = '0;
    i_awvalid = 1'b0;
    i_wdata   = '0;
    i_wvalid  = 1'b0;
    i_bready  = 1'b0;
    i_araddr  = '0;
    i_arvalid = 1'b0;
    i_rready  = 1'b0;
    repeat (5) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;

    // Idle control register read with a slow rready
    axi_read(`REG_CTRL, rd, 2);
    expect_equal("busy after reset", 32'(rd[31]), 32'd0);
    expect_equal("pointer after reset", 32'(rd[`INST_ADDR_BITS-1:0]), 32'd0);
    end_test("reset state");

    v = rand_operand();
    write_slot(10, v, 3);
    check_slot(10, v, 2);
    end_test("slot write and read back");

    x = rand_operand();
    y = rand_operand();
    write_slot(0, x);
    write_slot(1, y);
    write_inst(0, encode_inst(fp_cop_pkg::COPY_REG, 8'd0, 8'd2, 8'd0));
    write_inst(1, encode_inst(fp_cop_pkg::ADD_ELEMENT, 8'd0, 8'd1, 8'd3));
    write_inst(2, encode_inst(fp_cop_pkg::SUB_ELEMENT, 8'd0, 8'd1, 8'd4));
    write_inst(3, encode_inst(fp_cop_pkg::MUL_ELEMENT, 8'd0, 8'd1, 8'd5));
    write_inst(4, encode_inst(fp_cop_pkg::NOOP_WAIT, 8'd0, 8'd0, 8'd0));
    axi_write(`REG_CTRL, 32'd0);
    wait_idle();
    check_slot(2, x);
    check_slot(3, field_sum(x, y));
    check_slot(4, wrapped_diff(x, y));
    check_slot(5, reduced_product(x, y));
    end_test("mixed program");

    // First operand forced below the second
    x = 16'($unsigned($random(seed)) % 30000);
    y = 16'(30000 + $unsigned($random(seed)) % 30000);
    write_slot(6, x);
    write_slot(7, y);
    write_inst(8, encode_inst(fp_cop_pkg::SUB_ELEMENT, 8'd6, 8'd7, 8'd8));
    write_inst(9, encode_inst(fp_cop_pkg::NOOP_WAIT, 8'd0, 8'd0, 8'd0));
    axi_write(`REG_CTRL, 32'd8);
    wait_idle();
    check_slot(8, 16'(32'(x) + `FE_MODULUS - 32'(y)));
    end_test("subtraction wrap");

    // Multiply chain with host slot traffic while it runs
    x = rand_operand();
    y = rand_operand();
    write_slot(20, x);
    write_slot(21, y);
    chain[0] = reduced_product(x, y);
    write_inst(16, encode_inst(fp_cop_pkg::MUL_ELEMENT, 8'd20, 8'd21, 8'd22));
    for (int i = 1; i < 8; i++) begin
      chain[i] = reduced_product(chain[i-1], y);
      write_inst(16 + i, encode_inst(fp_cop_pkg::MUL_ELEMENT, 8'(21 + i), 8'd21, 8'(22 + i)));
    end
    write_inst(24, encode_inst(fp_cop_pkg::NOOP_WAIT, 8'd0, 8'd0, 8'd0));
    axi_write(`REG_CTRL, 32'd16);
    v = rand_operand();
    write_slot(100, v);
    check_slot(100, v);
    wait_idle();
    for (int i = 0; i < 8; i++) begin
      check_slot(22 + i, chain[i]);
    end
    end_test("host access during multiply chain");

    x = rand_operand();
    y = rand_operand();
    v = rand_operand();
    write_slot(30, x);
    write_slot(31, y);
    write_slot(40, v);
    write_inst(32, encode_inst(fp_cop_pkg::ADD_ELEMENT, 8'd30, 8'd31, 8'd40));
    write_inst(33, encode_inst(fp_cop_pkg::ADD_ELEMENT, 8'd30, 8'd31, 8'd41));
    write_inst(34, encode_inst(fp_cop_pkg::NOOP_WAIT, 8'd0, 8'd0, 8'd0));
    axi_write(`REG_CTRL, 32'd33);
    wait_idle();
    check_slot(40, v);
    check_slot(41, field_sum(x, y));
    axi_read(`REG_CTRL, rd);
    expect_equal("pointer at halt", 32'(rd[`INST_ADDR_BITS-1:0]), 32'd34);
    end_test("nonzero start pointer");

    $display("Summary: %0d tests, %0d checks, %0d errors", test_count, checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- testbench/fp_coprocessor_sva.sv
// Protocol assertions for the prime-field coprocessor
// AXI response holding, slot grant exclusion and arithmetic output stability
`timescale 1ns/1ps

module fp_coprocessor_sva (
  input logic            i_clk,
  input logic            i_rst,
  input logic            i_bvalid,
  input logic            i_bready,
  input logic            i_rvalid,
  input logic            i_rready,
  input logic [31:0]     i_rdata,
  input logic            i_br_gnt,
  input logic            i_sq_gnt,
  input logic            i_arith_val,
  input logic            i_arith_rdy,
  input fp_cop_pkg::fe_t i_arith_res
);

  // Write response waits for the host
  a_bvalid_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    i_bvalid && !i_bready |=> i_bvalid)
    else $error("bvalid dropped before bready");

  // Read data must not change while the host stalls
  a_rvalid_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    i_rvalid && !i_rready |=> i_rvalid && $stable(i_rdata))
    else $error("rvalid or rdata changed before rready");

  a_one_grant: assert property (@(posedge i_clk) disable iff (i_rst)
    !(i_br_gnt && i_sq_gnt))
    else $error("bridge and sequencer granted together");

  a_arith_stall: assert property (@(posedge i_clk) disable iff (i_rst)
    i_arith_val && !i_arith_rdy |=> i_arith_val && $stable(i_arith_res))
    else $error("arithmetic result moved under back-pressure");

endmodule

bind fp_coprocessor_top fp_coprocessor_sva fp_coprocessor_sva_inst (
  .i_clk       (i_clk),
  .i_rst       (i_rst),
  .i_bvalid    (o_bvalid),
  .i_bready    (i_bready),
  .i_rvalid    (o_rvalid),
  .i_rready    (i_rready),
  .i_rdata     (o_rdata),
  .i_br_gnt    (br_gnt),
  .i_sq_gnt    (sq_gnt),
  .i_arith_val (arith_out_val),
  .i_arith_rdy (arith_out_rdy),
  .i_arith_res (arith_res)
);

//--- src/fp_coprocessor_top.sv
// Prime-field coprocessor top level
// Memories, slot arbiter, AXI bridge, sequencer and arithmetic unit
`timescale 1ns/1ps
`include "fp_cop_params.svh"

module fp_coprocessor_top (
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic [31:0] i_awaddr,
  input  logic        i_awvalid,
  output logic        o_awready,
  input  logic [31:0] i_wdata,
  input  logic        i_wvalid,
  output logic        o_wready,
  output logic        o_bvalid,
  input  logic        i_bready,
  input  logic [31:0] i_araddr,
  input  logic        i_arvalid,
  output logic        o_arready,
  output logic [31:0] o_rdata,
  output logic        o_rvalid,
  input  logic        i_rready
);

  logic                       start;
  logic [`INST_ADDR_BITS-1:0] start_pt;
  logic                       busy;
  logic [`INST_ADDR_BITS-1:0] inst_pt;

  logic                       inst_we;
  logic [`INST_ADDR_BITS-1:0] inst_waddr;
  fp_cop_pkg::inst_t          inst_wdata;
  logic                       inst_re;
  logic [`INST_ADDR_BITS-1:0] inst_raddr;
  fp_cop_pkg::inst_t          inst_rdata;

  logic                       br_req;
  logic                       br_we;
  logic [`SLOT_ADDR_BITS-1:0] br_addr;
  fp_cop_pkg::fe_t            br_wdata;
  logic                       br_gnt;
  logic                       sq_req;
  logic                       sq_we;
  logic [`SLOT_ADDR_BITS-1:0] sq_addr;
  fp_cop_pkg::fe_t            sq_wdata;
  logic                       sq_gnt;
  fp_cop_pkg::fe_t            slot_rdata;

  logic                       arith_in_val;
  logic                       arith_in_rdy;
  fp_cop_pkg::arith_op_t      arith_op;
  fp_cop_pkg::fe_t            arith_x;
  fp_cop_pkg::fe_t            arith_y;
  logic                       arith_out_val;
  logic                       arith_out_rdy;
  fp_cop_pkg::fe_t            arith_res;

  // Instruction memory, bridge writes and sequencer reads
  slot_ram #(
    .entry_t (fp_cop_pkg::inst_t),
    .DEPTH   (`INST_DEPTH)
  ) inst_ram_inst (
    .i_clk   (i_clk),
    .i_we    (inst_we),
    .i_waddr (inst_waddr),
    .i_wdata (inst_wdata),
    .i_re    (inst_re),
    .i_raddr (inst_raddr),
    .o_rdata (inst_rdata)
  );

  slot_ram_arbiter slot_ram_arbiter_inst (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_br_req   (br_req),
    .i_br_we    (br_we),
    .i_br_addr  (br_addr),
    .i_br_wdata (br_wdata),
    .o_br_gnt   (br_gnt),
    .i_sq_req   (sq_req),
    .i_sq_we    (sq_we),
    .i_sq_addr  (sq_addr),
    .i_sq_wdata (sq_wdata),
    .o_sq_gnt   (sq_gnt),
    .o_rdata    (slot_rdata)
  );

  axi_lite_bridge axi_lite_bridge_inst (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_awaddr     (i_awaddr),
    .i_awvalid    (i_awvalid),
    .o_awready    (o_awready),
    .i_wdata      (i_wdata),
    .i_wvalid     (i_wvalid),
    .o_wready     (o_wready),
    .o_bvalid     (o_bvalid),
    .i_bready     (i_bready),
    .i_araddr     (i_araddr),
    .i_arvalid    (i_arvalid),
    .o_arready    (o_arready),
    .o_rdata      (o_rdata),
    .o_rvalid     (o_rvalid),
    .i_rready     (i_rready),
    .o_start      (start),
    .o_start_pt   (start_pt),
    .i_busy       (busy),
    .i_inst_pt    (inst_pt),
    .o_inst_we    (inst_we),
    .o_inst_addr  (inst_waddr),
    .o_inst_wdata (inst_wdata),
    .o_br_req     (br_req),
    .o_br_we      (br_we),
    .o_br_addr    (br_addr),
    .o_br_wdata   (br_wdata),
    .i_br_gnt     (br_gnt),
    .i_br_rdata   (slot_rdata)
  );

  inst_sequencer inst_sequencer_inst (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_start      (start),
    .i_start_pt   (start_pt),
    .o_busy       (busy),
    .o_inst_pt    (inst_pt),
    .o_inst_re    (inst_re),
    .o_inst_raddr (inst_raddr),
    .i_inst       (inst_rdata),
    .o_sq_req     (sq_req),
    .o_sq_we      (sq_we),
    .o_sq_addr    (sq_addr),
    .o_sq_wdata   (sq_wdata),
    .i_sq_gnt     (sq_gnt),
    .i_rdata      (slot_rdata),
    .o_arith_val  (arith_in_val),
    .i_arith_rdy  (arith_in_rdy),
    .o_arith_op   (arith_op),
    .o_arith_x    (arith_x),
    .o_arith_y    (arith_y),
    .i_arith_val  (arith_out_val),
    .o_arith_rdy  (arith_out_rdy),
    .i_arith_res  (arith_res)
  );

  mod_arith_unit mod_arith_unit_inst (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_val (arith_in_val),
    .o_rdy (arith_in_rdy),
    .i_op  (arith_op),
    .i_x   (arith_x),
    .i_y   (arith_y),
    .o_val (arith_out_val),
    .i_rdy (arith_out_rdy),
    .o_res (arith_res)
  );

endmodule

//--- src/inst_sequencer.sv
// Instruction sequencer
// Fetches, decodes and runs field instructions against slot memory
`timescale 1ns/1ps
`include "fp_cop_params.svh"

module inst_sequencer (
  input  logic                       i_clk,
  input  logic                       i_rst,
  input  logic                       i_start,
  input  logic [`INST_ADDR_BITS-1:0] i_start_pt,
  output logic                       o_busy,
  output logic [`INST_ADDR_BITS-1:0] o_inst_pt,
  output logic                       o_inst_re,
  output logic [`INST_ADDR_BITS-1:0] o_inst_raddr,
  input  fp_cop_pkg::inst_t          i_inst,
  output logic                       o_sq_req,
  output logic                       o_sq_we,
  output logic [`SLOT_ADDR_BITS-1:0] o_sq_addr,
  output fp_cop_pkg::fe_t            o_sq_wdata,
  input  logic                       i_sq_gnt,
  input  fp_cop_pkg::fe_t            i_rdata,
  output logic                       o_arith_val,
  input  logic                       i_arith_rdy,
  output fp_cop_pkg::arith_op_t      o_arith_op,
  output fp_cop_pkg::fe_t            o_arith_x,
  output fp_cop_pkg::fe_t            o_arith_y,
  input  logic                       i_arith_val,
  output logic                       o_arith_rdy,
  input  fp_cop_pkg::fe_t            i_arith_res
);

  typedef enum logic [3:0] {
    S_IDLE, S_FETCH, S_DECODE, S_RD_A, S_GET_A,
    S_RD_B, S_GET_B, S_ISSUE, S_RESULT, S_WR
  } state_t;

  state_t                     state;
  logic [`INST_ADDR_BITS-1:0] inst_pt;
  fp_cop_pkg::fe_t            op_x;
  fp_cop_pkg::fe_t            op_y;
  fp_cop_pkg::fe_t            result_l;
  logic                       is_copy;

  // Instruction read port holds its word until the next fetch
  assign is_copy      = (i_inst.opcode == fp_cop_pkg::COPY_REG);
  assign o_busy       = (state != S_IDLE);
  assign o_inst_pt    = inst_pt;
  assign o_inst_re    = (state == S_FETCH);
  assign o_inst_raddr = inst_pt;

  // Slot requests held for as long as the state waits on a grant
  assign o_sq_req   = (state == S_RD_A) || (state == S_RD_B) || (state == S_WR);
  assign o_sq_we    = (state == S_WR);
  assign o_sq_wdata = result_l;

  always_comb begin
    case (state)
      S_RD_A:  o_sq_addr = i_inst.a;
      S_RD_B:  o_sq_addr = i_inst.b;
      // COPY_REG writes to b, the others to c
      default: o_sq_addr = is_copy ? i_inst.b : i_inst.c;
    endcase
  end

  always_comb begin
    case (i_inst.opcode)
      fp_cop_pkg::ADD_ELEMENT: o_arith_op = fp_cop_pkg::ARITH_ADD;
      fp_cop_pkg::SUB_ELEMENT: o_arith_op = fp_cop_pkg::ARITH_SUB;
      default:                 o_arith_op = fp_cop_pkg::ARITH_MUL;
    endcase
  end

  assign o_arith_val = (state == S_ISSUE);
  assign o_arith_x   = op_x;
  assign o_arith_y   = op_y;
  assign o_arith_rdy = 1'b1;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state   <= S_IDLE;
      inst_pt <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (i_start) begin
            inst_pt <= i_start_pt;
            state   <= S_FETCH;
          end
        end
        S_FETCH: state <= S_DECODE;
        S_DECODE: begin
          case (i_inst.opcode)
            fp_cop_pkg::COPY_REG,
            fp_cop_pkg::ADD_ELEMENT,
            fp_cop_pkg::SUB_ELEMENT,
            fp_cop_pkg::MUL_ELEMENT: state <= S_RD_A;
            // NOOP_WAIT and unknown codes halt
            default: state <= S_IDLE;
          endcase
        end
        S_RD_A: begin
          if (i_sq_gnt) begin
            state <= S_GET_A;
          end
        end
        S_GET_A: begin
          op_x     <= i_rdata;
          result_l <= i_rdata;
          state    <= is_copy ? S_WR : S_RD_B;
        end
        S_RD_B: begin
          if (i_sq_gnt) begin
            state <= S_GET_B;
          end
        end
        S_GET_B: begin
          op_y  <= i_rdata;
          state <= S_ISSUE;
        end
        S_ISSUE: begin
          if (i_arith_rdy) begin
            state <= S_RESULT;
          end
        end
        S_RESULT: begin
          if (i_arith_val) begin
            result_l <= i_arith_res;
            state    <= S_WR;
          end
        end
        S_WR: begin
          if (i_sq_gnt) begin
            inst_pt <= inst_pt + 1'b1;
            state   <= S_FETCH;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

//--- src/axi_lite_bridge.sv
// AXI4-Lite slave for host access
// Control register, instruction writes and slot reads and writes
`timescale 1ns/1ps
`include "fp_cop_params.svh"

module axi_lite_bridge (
  input  logic                       i_clk,
  input  logic                       i_rst,
  input  logic [31:0]                i_awaddr,
  input  logic                       i_awvalid,
  output logic                       o_awready,
  input  logic [31:0]                i_wdata,
  input  logic                       i_wvalid,
  output logic                       o_wready,
  output logic                       o_bvalid,
  input  logic                       i_bready,
  input  logic [31:0]                i_araddr,
  input  logic                       i_arvalid,
  output logic                       o_arready,
  output logic [31:0]                o_rdata,
  output logic                       o_rvalid,
  input  logic                       i_rready,
  output logic                       o_start,
  output logic [`INST_ADDR_BITS-1:0] o_start_pt,
  input  logic                       i_busy,
  input  logic [`INST_ADDR_BITS-1:0] i_inst_pt,
  output logic                       o_inst_we,
  output logic [`INST_ADDR_BITS-1:0] o_inst_addr,
  output fp_cop_pkg::inst_t          o_inst_wdata,
  output logic                       o_br_req,
  output logic                       o_br_we,
  output logic [`SLOT_ADDR_BITS-1:0] o_br_addr,
  output fp_cop_pkg::fe_t            o_br_wdata,
  input  logic                       i_br_gnt,
  input  fp_cop_pkg::fe_t            i_br_rdata
);

  typedef enum logic [2:0] {
    ST_IDLE, ST_WR, ST_WR_SLOT, ST_BRESP,
    ST_RD, ST_RD_SLOT, ST_RD_DATA, ST_RRESP
  } state_t;

  state_t      state;
  logic [31:0] addr_l;
  logic [31:0] wdata_l;
  logic        is_ctrl;
  logic        is_inst;
  logic        is_slot;

  // Region decode on the latched address
  assign is_ctrl = (addr_l == `REG_CTRL);
  assign is_inst = ((addr_l & 32'hFFFF_F000) == `INST_BASE);
  assign is_slot = ((addr_l & 32'hFFFF_F000) == `SLOT_BASE);

  // Side effects fire in the cycle after the write is accepted
  assign o_start      = (state == ST_WR) && is_ctrl;
  assign o_start_pt   = wdata_l[`INST_ADDR_BITS-1:0];
  assign o_inst_we    = (state == ST_WR) && is_inst;
  assign o_inst_addr  = addr_l[2 +: `INST_ADDR_BITS];
  assign o_inst_wdata = fp_cop_pkg::inst_t'(wdata_l);
  assign o_br_we      = (state == ST_WR_SLOT);
  assign o_br_addr    = addr_l[2 +: `SLOT_ADDR_BITS];
  assign o_br_wdata   = wdata_l[`FE_BITS-1:0];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state     <= ST_IDLE;
      o_awready <= 1'b0;
      o_wready  <= 1'b0;
      o_arready <= 1'b0;
      o_bvalid  <= 1'b0;
      o_rvalid  <= 1'b0;
      o_br_req  <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          // Writes first, one transaction at a time
          if (i_awvalid && i_wvalid) begin
            o_awready <= 1'b1;
            o_wready  <= 1'b1;
            addr_l    <= i_awaddr;
            wdata_l   <= i_wdata;
            state     <= ST_WR;
          end else if (i_arvalid) begin
            o_arready <= 1'b1;
            addr_l    <= i_araddr;
            state     <= ST_RD;
          end
        end
        ST_WR: begin
          o_awready <= 1'b0;
          o_wready  <= 1'b0;
          if (is_slot) begin
            o_br_req <= 1'b1;
            state    <= ST_WR_SLOT;
          end else begin
            o_bvalid <= 1'b1;
            state    <= ST_BRESP;
          end
        end
        ST_WR_SLOT: begin
          if (i_br_gnt) begin
            o_br_req <= 1'b0;
            o_bvalid <= 1'b1;
            state    <= ST_BRESP;
          end
        end
        ST_BRESP: begin
          if (i_bready) begin
            o_bvalid <= 1'b0;
            state    <= ST_IDLE;
          end
        end
        ST_RD: begin
          o_arready <= 1'b0;
          if (is_slot) begin
            o_br_req <= 1'b1;
            state    <= ST_RD_SLOT;
          end else begin
            // Busy in bit 31, instruction pointer at the bottom
            o_rdata  <= is_ctrl ? {i_busy, {(31 - `INST_ADDR_BITS){1'b0}}, i_inst_pt} : 32'd0;
            o_rvalid <= 1'b1;
            state    <= ST_RRESP;
          end
        end
        ST_RD_SLOT: begin
          if (i_br_gnt) begin
            o_br_req <= 1'b0;
            state    <= ST_RD_DATA;
          end
        end
        ST_RD_DATA: begin
          // Slot data lands one cycle after the grant
          o_rdata  <= 32'(i_br_rdata);
          o_rvalid <= 1'b1;
          state    <= ST_RRESP;
        end
        ST_RRESP: begin
          if (i_rready) begin
            o_rvalid <= 1'b0;
            state    <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

//--- src/slot_ram_arbiter.sv
// Round-robin arbiter between AXI bridge and sequencer
// Owns the single-port slot memory
`timescale 1ns/1ps
`include "fp_cop_params.svh"

module slot_ram_arbiter (
  input  logic                       i_clk,
  input  logic                       i_rst,
  input  logic                       i_br_req,
  input  logic                       i_br_we,
  input  logic [`SLOT_ADDR_BITS-1:0] i_br_addr,
  input  fp_cop_pkg::fe_t            i_br_wdata,
  output logic                       o_br_gnt,
  input  logic                       i_sq_req,
  input  logic                       i_sq_we,
  input  logic [`SLOT_ADDR_BITS-1:0] i_sq_addr,
  input  fp_cop_pkg::fe_t            i_sq_wdata,
  output logic                       o_sq_gnt,
  output fp_cop_pkg::fe_t            o_rdata
);

  logic                       last_sq;
  logic                       mem_we;
  logic [`SLOT_ADDR_BITS-1:0] mem_addr;
  fp_cop_pkg::fe_t            mem_wdata;

  // Bridge wins unless both ask and it was served last
  assign o_br_gnt = i_br_req && (!i_sq_req || last_sq);
  assign o_sq_gnt = i_sq_req && !o_br_gnt;

  // Memory port follows the winner
  assign mem_we    = o_br_gnt ? i_br_we : (o_sq_gnt && i_sq_we);
  assign mem_addr  = o_br_gnt ? i_br_addr : i_sq_addr;
  assign mem_wdata = o_br_gnt ? i_br_wdata : i_sq_wdata;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      last_sq <= 1'b1;
    end else if (o_br_gnt) begin
      last_sq <= 1'b0;
    end else if (o_sq_gnt) begin
      last_sq <= 1'b1;
    end
  end

  slot_ram #(
    .entry_t (fp_cop_pkg::fe_t),
    .DEPTH   (`SLOT_DEPTH)
  ) slot_ram_inst (
    .i_clk   (i_clk),
    .i_we    (mem_we),
    .i_waddr (mem_addr),
    .i_wdata (mem_wdata),
    .i_re    (o_br_gnt || o_sq_gnt),
    .i_raddr (mem_addr),
    .o_rdata (o_rdata)
  );

endmodule

//--- src/mod_arith_unit.sv
// Three-stage modular add, subtract and multiply
// Whole pipeline stalls while the result is not taken
`timescale 1ns/1ps
`include "fp_cop_params.svh"

module mod_arith_unit (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_val,
  output logic                  o_rdy,
  input  fp_cop_pkg::arith_op_t i_op,
  input  fp_cop_pkg::fe_t       i_x,
  input  fp_cop_pkg::fe_t       i_y,
  output logic                  o_val,
  input  logic                  i_rdy,
  output fp_cop_pkg::fe_t       o_res
);

  localparam int RAW_BITS = 2 * `FE_BITS;

  logic                  adv;
  logic                  s1_val;
  logic                  s2_val;
  fp_cop_pkg::arith_op_t s1_op;
  logic [RAW_BITS-1:0]   raw_in;
  logic [RAW_BITS-1:0]   s1_raw;
  fp_cop_pkg::fe_t       red;
  fp_cop_pkg::fe_t       s2_res;

  // Stages move only when the output register is free
  assign adv   = !o_val || i_rdy;
  // Stage one can still fill while empty
  assign o_rdy = adv || !s1_val;

  // Stage one, raw sum, difference with borrow, or full product
  always_comb begin
    case (i_op)
      fp_cop_pkg::ARITH_ADD: raw_in = RAW_BITS'(i_x) + RAW_BITS'(i_y);
      fp_cop_pkg::ARITH_SUB: raw_in = RAW_BITS'({1'b0, i_x} - {1'b0, i_y});
      default:               raw_in = RAW_BITS'(i_x) * RAW_BITS'(i_y);
    endcase
  end

  // Stage two, reduce into [0, modulus)
  always_comb begin
    case (s1_op)
      fp_cop_pkg::ARITH_ADD: begin
        if (s1_raw >= RAW_BITS'(`FE_MODULUS)) begin
          red = fp_cop_pkg::fe_t'(s1_raw - `FE_MODULUS);
        end else begin
          red = fp_cop_pkg::fe_t'(s1_raw);
        end
      end
      fp_cop_pkg::ARITH_SUB: begin
        // Borrow set means wrap by adding the modulus
        if (s1_raw[`FE_BITS]) begin
          red = fp_cop_pkg::fe_t'(s1_raw + `FE_MODULUS);
        end else begin
          red = fp_cop_pkg::fe_t'(s1_raw);
        end
      end
      default: red = fp_cop_pkg::fe_t'(s1_raw % `FE_MODULUS);
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      s1_val <= 1'b0;
      s2_val <= 1'b0;
      o_val  <= 1'b0;
    end else begin
      if (o_rdy) begin
        s1_val <= i_val;
      end
      if (adv) begin
        s2_val <= s1_val;
        o_val  <= s2_val;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_rdy) begin
      s1_op  <= i_op;
      s1_raw <= raw_in;
    end
    if (adv) begin
      s2_res <= red;
      o_res  <= s2_res;
    end
  end

endmodule

//--- src/slot_ram.sv
// Simple dual-port memory with registered read
// Entry type set by parameter, write-first on address collision
`timescale 1ns/1ps

module slot_ram #(
  parameter type entry_t = logic [31:0],
  parameter int  DEPTH   = 64
) (
  input  logic                     i_clk,
  input  logic                     i_we,
  input  logic [$clog2(DEPTH)-1:0] i_waddr,
  input  entry_t                   i_wdata,
  input  logic                     i_re,
  input  logic [$clog2(DEPTH)-1:0] i_raddr,
  output entry_t                   o_rdata
);

  entry_t mem [DEPTH];

  always_ff @(posedge i_clk) begin
    if (i_we) begin
      mem[i_waddr] <= i_wdata;
    end
    // New data wins when both ports hit one entry
    if (i_re) begin
      if (i_we && (i_waddr == i_raddr)) begin
        o_rdata <= i_wdata;
      end else begin
        o_rdata <= mem[i_raddr];
      end
    end
  end

endmodule

//--- src/fp_cop_pkg.sv
// Shared types for the prime-field coprocessor
// Field elements, opcodes, instruction words and arithmetic ops
`include "fp_cop_params.svh"

package fp_cop_pkg;

  typedef logic [`FE_BITS-1:0] fe_t;

  typedef enum logic [3:0] {
    NOOP_WAIT   = 4'd0,
    COPY_REG    = 4'd1,
    ADD_ELEMENT = 4'd2,
    SUB_ELEMENT = 4'd3,
    MUL_ELEMENT = 4'd4
  } opcode_t;

  // Instruction word, fields from the MSB down
  typedef struct packed {
    opcode_t                    opcode;
    logic [3:0]                 rsvd;
    logic [`SLOT_ADDR_BITS-1:0] a;
    logic [`SLOT_ADDR_BITS-1:0] b;
    logic [`SLOT_ADDR_BITS-1:0] c;
  } inst_t;

  typedef enum logic [1:0] {
    ARITH_ADD,
    ARITH_SUB,
    ARITH_MUL
  } arith_op_t;

endpackage

//--- include/fp_cop_params.svh
// Prime-field coprocessor parameters
// Widths, memory depths, the field modulus and AXI register map
`ifndef FP_COP_PARAMS_SVH
`define FP_COP_PARAMS_SVH

// Field element width and the 16-bit prime
`define FE_BITS        16
`define FE_MODULUS     65521

// Memory depths and address widths
`define INST_DEPTH     64
`define SLOT_DEPTH     256
`define SLOT_ADDR_BITS 8
`define INST_ADDR_BITS 6

// AXI4-Lite address map
`define REG_CTRL       32'h0000_0000
`define INST_BASE      32'h0000_1000
`define SLOT_BASE      32'h0000_2000

`endif
